// File: files.f
+incdir+test
src/invadersPkg.sv
src/pixelStageIf.sv
src/glyphCellLocator.sv
src/cellBoard.sv
src/spriteRom.sv
src/pixelComposer.sv
src/invadersBitGen.sv
test/bitGenTb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f files.f --top-module bitGenTb -o bitGenSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/bitGenSim > sim.log 2>&1
simStatus=$?
cat sim.log

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^Verification passed$" sim.log; then
    exit 0
fi

echo "Pass message not found in sim.log"
exit 1

// File: test/bitGenChecks.svh
`ifndef BITGEN_CHECKS_SVH
`define BITGEN_CHECKS_SVH

int unsigned lcgState = 46;

function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return (lcgState >> 16) & 32'h7fff;   // Upper bits have the longer period
endfunction

task automatic failStop(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "Stopped at the first error");
endtask

task automatic checkColor(input string testName, input invadersPkg::pixelColor expected,
                          input invadersPkg::pixelColor actual);
    if (actual !== expected) begin
        failStop($sformatf("[FAIL] %s: expected %0d, actual %0d", testName, expected, actual));
    end
endtask

task automatic checkCode(input string testName, input invadersPkg::cellCode expected,
                         input invadersPkg::cellCode actual);
    if (actual !== expected) begin
        failStop($sformatf("[FAIL] %s: expected %04h, actual %04h", testName, expected, actual));
    end
endtask

// Counts falling edges against a time limit
task automatic waitNegedges(input int count, input string what);
    int seen;
    time startTime;
    seen = 0;
    startTime = $time;
    while (seen < count) begin
        @(negedge clk);
        seen++;
        if ($time - startTime > time'(count + 1) * clkPeriod) begin
            failStop($sformatf("Timed out waiting for %s", what));
        end
    end
endtask

`endif

// File: test/bitGenTb.sv
`timescale 1ns/1ps
`default_nettype none

module bitGenTb;

    localparam int gridCols = invadersPkg::defaultGridCols;
    localparam int gridRows = invadersPkg::defaultGridRows;
    localparam int numCells = gridCols * gridRows;
    localparam int idxW = $clog2(numCells);
    localparam int clkPeriod = 10;
    localparam int latency = 3;             // Rising edges from scan sample to rgb
    localparam int cellSize = 1 << invadersPkg::cellShift;
    localparam int blockSize = 1 << invadersPkg::blockShift;
    localparam int gridRight = invadersPkg::gridLeft + gridCols * cellSize;
    localparam int gridBottom = invadersPkg::gridTop + gridRows * cellSize;
    localparam int streamLen = 40;
    localparam int tableSize = 10;

    logic clk = 1'b0;
    logic rst;
    logic bright;
    invadersPkg::screenCoord hCount;
    invadersPkg::screenCoord vCount;
    logic cellWrEn;
    logic [idxW-1:0] cellWrAddr;
    invadersPkg::cellCode cellWrData;
    invadersPkg::pixelColor rgb;

    invadersPkg::cellCode boardModel [numCells];

    // Known sprite pixels as (row, column)
    invadersPkg::glyphSel tableGlyph [tableSize] = '{2'd1, 2'd1, 2'd1, 2'd1, 2'd2,
                                                     2'd2, 2'd2, 2'd3, 2'd3, 2'd3};
    int tableRow [tableSize] = '{2, 3, 7, 0, 0, 5, 6, 0, 4, 5};
    int tableCol [tableSize] = '{3, 3, 2, 0, 0, 3, 5, 0, 2, 3};
    invadersPkg::pixelColor tableColor [tableSize] = '{
        invadersPkg::colorWhite, invadersPkg::colorBlue, invadersPkg::colorRed,
        invadersPkg::colorBlack, invadersPkg::colorBlue, invadersPkg::colorRed,
        invadersPkg::colorBlack, invadersPkg::colorYellow, invadersPkg::colorRed,
        invadersPkg::colorBlue
    };

    `include "bitGenChecks.svh"

    invadersBitGen #(
        .gridCols(gridCols),
        .gridRows(gridRows)
    ) dut (
        .clk(clk),
        .rst(rst),
        .bright(bright),
        .hCount(hCount),
        .vCount(vCount),
        .cellWrEn(cellWrEn),
        .cellWrAddr(cellWrAddr),
        .cellWrData(cellWrData),
        .rgb(rgb)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic void lookupTable(input invadersPkg::glyphSel glyph, input int row,
                                        input int col, output logic found,
                                        output invadersPkg::pixelColor color);
        found = 1'b0;
        color = invadersPkg::colorBlack;
        for (int i = 0; i < tableSize; i++) begin
            if (tableGlyph[i] == glyph && tableRow[i] == row && tableCol[i] == col) begin
                found = 1'b1;
                color = tableColor[i];
            end
        end
    endfunction

    // Expected rgb from the blanking, bullet and sprite rules
    function automatic void predictColor(input int h, input int v, input logic b,
                                         output logic known,
                                         output invadersPkg::pixelColor color);
        int bRow;
        int bCol;
        invadersPkg::cellCode code;
        known = 1'b1;
        color = invadersPkg::colorBlack;
        if (!b || h < invadersPkg::gridLeft || h >= gridRight
                || v < invadersPkg::gridTop || v >= gridBottom) begin
            return;
        end
        code = boardModel[((h - invadersPkg::gridLeft) / cellSize) * gridRows
                          + (v - invadersPkg::gridTop) / cellSize];
        bRow = ((v - invadersPkg::gridTop) / blockSize) % 8;
        bCol = ((h - invadersPkg::gridLeft) / blockSize) % 8;
        if (code.bulletUp && bRow <= 1 && (bCol == 3 || bCol == 4)) begin
            color = invadersPkg::colorCyan;
        end else if (code.bulletDown && bRow >= 6 && (bCol == 3 || bCol == 4)) begin
            color = invadersPkg::colorRed;
        end else if (code.glyph != invadersPkg::glyphNone) begin
            lookupTable(code.glyph, bRow, bCol, known, color);
        end
    endfunction

    task automatic driveIdle();
        bright = 1'b0;
        hCount = '0;
        vCount = '0;
    endtask

    task automatic writeCell(input int idx, input invadersPkg::cellCode code);
        cellWrEn = 1'b1;
        cellWrAddr = idxW'(idx);
        cellWrData = code;
        boardModel[idx] = code;
        waitNegedges(1, "cell write");
        cellWrEn = 1'b0;
    endtask

    task automatic fillBoard(input invadersPkg::cellCode code);
        for (int i = 0; i < numCells; i++) begin
            writeCell(i, code);
        end
    endtask

    task automatic samplePixel(input int h, input int v, input logic b,
                               output invadersPkg::pixelColor color);
        bright = b;
        hCount = invadersPkg::screenCoord'(h);
        vCount = invadersPkg::screenCoord'(v);
        waitNegedges(1, "pixel sample");
        driveIdle();                        // Single-cycle pixel pins the latency
        waitNegedges(latency - 1, "pixel result");
        color = rgb;
    endtask

    task automatic checkCellPixel(input string testName, input int idx, input int bRow,
                                  input int bCol, input logic b,
                                  input invadersPkg::pixelColor expected);
        int h;
        int v;
        invadersPkg::pixelColor actual;
        h = invadersPkg::gridLeft + (idx / gridRows) * cellSize + bCol * blockSize + 3;
        v = invadersPkg::gridTop + (idx % gridRows) * cellSize + bRow * blockSize + 5;
        samplePixel(h, v, b, actual);
        checkColor(testName, expected, actual);
    endtask

    task automatic checkScreenPixel(input string testName, input int h, input int v,
                                    input invadersPkg::pixelColor expected);
        invadersPkg::pixelColor actual;
        samplePixel(h, v, 1'b1, actual);
        checkColor(testName, expected, actual);
    endtask

    task automatic resetAndBlanking();
        invadersPkg::cellCode code;
        checkColor("reset", invadersPkg::colorBlack, rgb);
        code = '0;
        code.glyph = invadersPkg::glyphShip;
        writeCell(0, code);
        checkCellPixel("blanking", 0, 2, 3, 1'b0, invadersPkg::colorBlack);
        checkCellPixel("blanking lifted", 0, 2, 3, 1'b1, invadersPkg::colorWhite);
    endtask

    task automatic tablePixels();
        invadersPkg::cellCode code;
        for (int i = 0; i < tableSize; i++) begin
            code = '0;
            code.glyph = tableGlyph[i];
            writeCell(0, code);
            checkCellPixel($sformatf("table entry %0d", i), 0, tableRow[i], tableCol[i],
                           1'b1, tableColor[i]);
        end
    endtask

    task automatic columnMajorPlacement();
        int idx;
        int down;
        int across;
        invadersPkg::cellCode code;
        code = '0;
        code.glyph = invadersPkg::glyphShip;
        for (int n = 0; n < 6; n++) begin
            idx = int'(nextRand() % numCells);
            fillBoard('0);
            writeCell(idx, code);
            down = (idx % gridRows + 1 < gridRows) ? idx + 1 : idx - 1;
            across = (idx / gridRows + 1 < gridCols) ? idx + gridRows : idx - gridRows;
            checkCellPixel($sformatf("placement cell %0d", idx), idx, 2, 3, 1'b1,
                           invadersPkg::colorWhite);
            checkCellPixel("vertical neighbour", down, 2, 3, 1'b1, invadersPkg::colorBlack);
            checkCellPixel("horizontal neighbour", across, 2, 3, 1'b1,
                           invadersPkg::colorBlack);
        end
    endtask

    task automatic bulletOverlays();
        invadersPkg::cellCode code;
        fillBoard('0);
        code = '0;
        code.bulletUp = 1'b1;
        writeCell(7, code);
        checkCellPixel("bullet up", 7, 0, 3, 1'b1, invadersPkg::colorCyan);
        checkCellPixel("bullet up far end", 7, 7, 4, 1'b1, invadersPkg::colorBlack);
        code = '0;
        code.bulletDown = 1'b1;
        writeCell(13, code);
        checkCellPixel("bullet down", 13, 7, 4, 1'b1, invadersPkg::colorRed);
        code = '0;
        code.bulletUp = 1'b1;
        code.glyph = invadersPkg::glyphAlienB;
        writeCell(29, code);
        checkCellPixel("alien B bullet", 29, 0, 3, 1'b1, invadersPkg::colorCyan);
        checkCellPixel("alien B body", 29, 0, 0, 1'b1, invadersPkg::colorYellow);
    endtask

    task automatic gridBounds();
        invadersPkg::cellCode code;
        code = '0;
        code.glyph = invadersPkg::glyphAlienA;
        fillBoard(code);
        checkScreenPixel("left of grid", 127, 64, invadersPkg::colorBlack);
        checkScreenPixel("grid corner", 128, 64, invadersPkg::colorBlue);
        checkScreenPixel("right of grid", 448, 100, invadersPkg::colorBlack);
        checkScreenPixel("below grid", 200, 448, invadersPkg::colorBlack);
        code.spare = 12'hA5C;
        writeCell(0, code);
        checkCode("spare bits stored", code, dut.board.cells[0]);
        checkScreenPixel("spare bits ignored", 128, 64, invadersPkg::colorBlue);
    endtask

    task automatic backToBackStream();
        invadersPkg::pixelColor expColor [streamLen];
        logic expKnown [streamLen];
        invadersPkg::cellCode code;
        int idx;
        int entry;
        int h;
        int v;
        int checked;
        logic b;
        for (int i = 0; i < numCells; i++) begin
            code = '0;
            code.glyph = invadersPkg::glyphSel'(nextRand() % 4);
            code.bulletUp = (nextRand() % 4 == 0);
            code.bulletDown = (nextRand() % 4 == 0);
            code.spare = 12'(nextRand());
            writeCell(i, code);
        end
        checked = 0;
        for (int j = 0; j < streamLen + latency; j++) begin
            if (j >= latency && expKnown[j - latency]) begin
                checkColor($sformatf("stream pixel %0d", j - latency),
                           expColor[j - latency], rgb);
                checked++;
            end
            if (j < streamLen) begin
                b = (nextRand() % 8 != 0);
                if (nextRand() % 6 == 0) begin
                    h = int'(nextRand() % 640);     // Anywhere on screen
                    v = int'(nextRand() % 480);
                end else begin
                    idx = int'(nextRand() % numCells);
                    entry = int'(nextRand() % tableSize);
                    h = invadersPkg::gridLeft + (idx / gridRows) * cellSize
                        + tableCol[entry] * blockSize + int'(nextRand() % 8);
                    v = invadersPkg::gridTop + (idx % gridRows) * cellSize
                        + tableRow[entry] * blockSize + int'(nextRand() % 8);
                end
                predictColor(h, v, b, expKnown[j], expColor[j]);
                bright = b;
                hCount = invadersPkg::screenCoord'(h);
                vCount = invadersPkg::screenCoord'(v);
            end else begin
                driveIdle();
            end
            waitNegedges(1, "stream cycle");
        end
        if (checked < 5) begin
            failStop("Streaming test could predict too few pixels to be useful");
        end
    endtask

    initial begin : watchdog
        int ticks;
        ticks = 0;
        while (ticks < 2000) begin
            #100;
            ticks++;
        end
        failStop("Simulation ran past its time limit");
    end

    initial begin
        rst = 1'b1;
        cellWrEn = 1'b0;
        cellWrAddr = '0;
        cellWrData = '0;
        driveIdle();
        for (int i = 0; i < numCells; i++) begin
            boardModel[i] = '0;
        end
        waitNegedges(3, "reset");   // Three rising edges in reset
        rst = 1'b0;
        resetAndBlanking();
        tablePixels();
        columnMajorPlacement();
        bulletOverlays();
        gridBounds();
        backToBackStream();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/invadersBitGen.sv
`timescale 1ns/1ps
`default_nettype none

module invadersBitGen #(
    parameter int gridCols = invadersPkg::defaultGridCols,
    parameter int gridRows = invadersPkg::defaultGridRows,
    localparam int idxW = $clog2(gridCols * gridRows)
) (
    input logic clk,
    input logic rst,
    input logic bright,
    input invadersPkg::screenCoord hCount,
    input invadersPkg::screenCoord vCount,
    input logic cellWrEn,
    input logic [idxW-1:0] cellWrAddr,
    input invadersPkg::cellCode cellWrData,
    output invadersPkg::pixelColor rgb
);

    invadersPkg::cellCode code;

    pixelStageIf #(.idxWidth(idxW)) stage1 ();
    pixelStageIf #(.idxWidth(idxW)) stage2 ();

    glyphCellLocator #(
        .gridCols(gridCols),
        .gridRows(gridRows)
    ) locator (
        .clk(clk),
        .rst(rst),
        .bright(bright),
        .hCount(hCount),
        .vCount(vCount),
        .stage1(stage1.src)
    );

    cellBoard #(
        .gridCols(gridCols),
        .gridRows(gridRows)
    ) board (
        .clk(clk),
        .rst(rst),
        .cellWrEn(cellWrEn),
        .cellWrAddr(cellWrAddr),
        .cellWrData(cellWrData),
        .stage1(stage1.dst),
        .stage2(stage2.src),
        .code(code)
    );

    pixelComposer composer (
        .clk(clk),
        .rst(rst),
        .stage2(stage2.dst),
        .code(code),
        .rgb(rgb)
    );

endmodule

`default_nettype wire

// File: src/pixelComposer.sv
`timescale 1ns/1ps
`default_nettype none

module pixelComposer (
    input logic clk,
    input logic rst,
    pixelStageIf.dst stage2,
    input invadersPkg::cellCode code,
    output invadersPkg::pixelColor rgb
);

    invadersPkg::pixelColor spriteColor;
    invadersPkg::pixelColor nextRgb;
    logic bulletCol;
    logic upRows;
    logic downRows;

    spriteRom rom (
        .glyph(code.glyph),
        .blockRow(stage2.blockRow),
        .blockCol(stage2.blockCol),
        .color(spriteColor)
    );

    // Bullets are two blocks wide in the middle of the cell
    assign bulletCol = (stage2.blockCol == 3'd3) || (stage2.blockCol == 3'd4);
    assign upRows = (stage2.blockRow <= 3'd1);
    assign downRows = (stage2.blockRow >= 3'd6);

    always_comb begin
        nextRgb = spriteColor;
        if (code.bulletUp && upRows && bulletCol) begin
            nextRgb = invadersPkg::colorCyan;
        end
        if (code.bulletDown && downRows && bulletCol) begin
            nextRgb = invadersPkg::colorRed;
        end
        if (!stage2.visible || !stage2.inCell) begin
            nextRgb = invadersPkg::colorBlack;   // Blanking wins
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb <= invadersPkg::colorBlack;
        end else begin
            rgb <= nextRgb;
        end
    end

endmodule

`default_nettype wire

// File: src/spriteRom.sv
`timescale 1ns/1ps
`default_nettype none

module spriteRom (
    input invadersPkg::glyphSel glyph,
    input invadersPkg::blockIdx blockRow,
    input invadersPkg::blockIdx blockCol,
    output invadersPkg::pixelColor color
);

    // One octal digit per block with column 0 leftmost
    localparam logic [0:7][2:0] shipRows [8] = '{
        24'o00000000,
        24'o00000000,
        24'o00077000,
        24'o00711700,
        24'o07111170,
        24'o07111170,
        24'o00711700,
        24'o00400400    // Exhausts
    };

    localparam logic [0:7][2:0] alienARows [8] = '{
        24'o10000001,
        24'o01000010,
        24'o01100110,
        24'o00111100,
        24'o00011000,
        24'o00044000,   // Eyes
        24'o00000000,
        24'o00000000
    };

    localparam logic [0:7][2:0] alienBRows [8] = '{
        24'o60000006,
        24'o06000060,
        24'o00666600,
        24'o00600600,
        24'o06400460,
        24'o60411406,
        24'o00000000,
        24'o00000000
    };

    always_comb begin
        case (glyph)
            invadersPkg::glyphNone: begin
                color = invadersPkg::colorBlack;
            end
            invadersPkg::glyphShip: begin
                color = shipRows[blockRow][blockCol];
            end
            invadersPkg::glyphAlienA: begin
                color = alienARows[blockRow][blockCol];
            end
            invadersPkg::glyphAlienB: begin
                color = alienBRows[blockRow][blockCol];
            end
            default: begin
                color = invadersPkg::colorBlack;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/cellBoard.sv
`timescale 1ns/1ps
`default_nettype none

module cellBoard #(
    parameter int gridCols = invadersPkg::defaultGridCols,
    parameter int gridRows = invadersPkg::defaultGridRows,
    localparam int idxW = $clog2(gridCols * gridRows)
) (
    input logic clk,
    input logic rst,
    input logic cellWrEn,
    input logic [idxW-1:0] cellWrAddr,
    input invadersPkg::cellCode cellWrData,
    pixelStageIf.dst stage1,
    pixelStageIf.src stage2,
    output invadersPkg::cellCode code
);

    localparam int numCells = gridCols * gridRows;

    invadersPkg::cellCode cells [numCells];
    logic wrOk;
    logic rdOk;

    assign wrOk = cellWrEn && (cellWrAddr < numCells);         // Drop writes past the grid
    assign rdOk = stage1.inCell && (stage1.cellIndex < numCells);

    always_ff @(posedge clk) begin
        if (rst) begin
            cells <= '{default: '0};
        end else if (wrOk) begin
            cells[cellWrAddr] <= cellWrData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage2.visible <= 1'b0;
            stage2.inCell <= 1'b0;
        end else begin
            stage2.visible <= stage1.visible;
            stage2.inCell <= stage1.inCell;
        end
    end

    // Read sees the old entry when a write hits the same edge
    always_ff @(posedge clk) begin
        code <= rdOk ? cells[stage1.cellIndex] : '0;
        stage2.cellIndex <= stage1.cellIndex;
        stage2.blockRow <= stage1.blockRow;
        stage2.blockCol <= stage1.blockCol;
    end

endmodule

`default_nettype wire

// File: src/glyphCellLocator.sv
`timescale 1ns/1ps
`default_nettype none

module glyphCellLocator #(
    parameter int gridCols = invadersPkg::defaultGridCols,
    parameter int gridRows = invadersPkg::defaultGridRows
) (
    input logic clk,
    input logic rst,
    input logic bright,
    input invadersPkg::screenCoord hCount,
    input invadersPkg::screenCoord vCount,
    pixelStageIf.src stage1
);

    localparam int numCells = gridCols * gridRows;
    localparam int idxW = $clog2(numCells);
    localparam int cellBits = invadersPkg::screenBits - invadersPkg::cellShift;
    localparam int gridRight = invadersPkg::gridLeft + (gridCols << invadersPkg::cellShift);
    localparam int gridBottom = invadersPkg::gridTop + (gridRows << invadersPkg::cellShift);

    invadersPkg::screenCoord relX;
    invadersPkg::screenCoord relY;
    logic [cellBits-1:0] cellCol;
    logic [cellBits-1:0] cellRow;
    logic [idxW-1:0] index;
    logic inGrid;

    // Offsets from the grid origin wrap outside the grid
    assign relX = hCount - invadersPkg::screenCoord'(invadersPkg::gridLeft);
    assign relY = vCount - invadersPkg::screenCoord'(invadersPkg::gridTop);

    // Half-open on both axes
    assign inGrid = (hCount >= invadersPkg::gridLeft) && (hCount < gridRight)
                 && (vCount >= invadersPkg::gridTop) && (vCount < gridBottom);

    assign cellCol = relX[invadersPkg::screenBits-1:invadersPkg::cellShift];
    assign cellRow = relY[invadersPkg::screenBits-1:invadersPkg::cellShift];

    assign index = idxW'(cellCol * gridRows + cellRow);   // Column-major

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1.visible <= 1'b0;
            stage1.inCell <= 1'b0;
        end else begin
            stage1.visible <= bright && inGrid;
            stage1.inCell <= inGrid;
        end
    end

    always_ff @(posedge clk) begin
        stage1.cellIndex <= index;
        stage1.blockRow <= relY[invadersPkg::blockShift +: 3];
        stage1.blockCol <= relX[invadersPkg::blockShift +: 3];
    end

endmodule

`default_nettype wire

// File: src/pixelStageIf.sv
`timescale 1ns/1ps
`default_nettype none

interface pixelStageIf #(
    parameter int idxWidth = 5
);

    logic visible;                      // Bright and inside the grid
    logic inCell;
    logic [idxWidth-1:0] cellIndex;     // Column-major cell number
    invadersPkg::blockIdx blockRow;
    invadersPkg::blockIdx blockCol;

    modport src (
        output visible, inCell, cellIndex, blockRow, blockCol
    );

    modport dst (
        input visible, inCell, cellIndex, blockRow, blockCol
    );

endinterface

`default_nettype wire

// File: src/invadersPkg.sv
`default_nettype none

package invadersPkg;

    localparam int screenBits = 10;

    // Bit 2 red, bit 1 green, bit 0 blue
    typedef logic [2:0] pixelColor;

    localparam pixelColor colorBlack = 3'd0;
    localparam pixelColor colorBlue = 3'd1;
    localparam pixelColor colorCyan = 3'd3;
    localparam pixelColor colorRed = 3'd4;
    localparam pixelColor colorYellow = 3'd6;
    localparam pixelColor colorWhite = 7;

    typedef logic [screenBits-1:0] screenCoord;

    typedef logic [2:0] blockIdx;   // Block row or column inside a cell

    typedef logic [1:0] glyphSel;

    localparam glyphSel glyphNone = 2'd0;
    localparam glyphSel glyphShip = 2'd1;
    localparam glyphSel glyphAlienA = 2'd2;
    localparam glyphSel glyphAlienB = 2'd3;

    typedef struct packed {
        logic [11:0] spare;         // Stored, never decoded
        logic bulletDown;
        logic bulletUp;
        glyphSel glyph;
    } cellCode;

    // Grid placement on the screen
    localparam int gridLeft = 128;
    localparam int gridTop = 64;
    localparam int cellShift = 6;   // 64-pixel cells
    localparam int blockShift = 3;  // 8-pixel blocks

    localparam int defaultGridCols = 5;
    localparam int defaultGridRows = 6;

endpackage

`default_nettype wire
